//--- hdl/mem_fifo_config.svh
`ifndef MEM_FIFO_CONFIG_SVH
`define MEM_FIFO_CONFIG_SVH

// memory port geometry
`define MEM_AW 10          // word address width
`define MEM_DW 32          // data width
`define MEM_BW 8           // byte width, one enable per byte

// buffering
`define MEM_FIFO_DEPTH 4   // default depth of both FIFOs

// SRAM model size, addresses wrap modulo this
`define SRAM_WORDS 256

`endif

//--- hdl/mem_fifo_pkg.sv
`include "mem_fifo_config.svh"

package mem_fifo_pkg;

  // request bundle, used on the core side, in the outgoing FIFO
  // and on the memory side
  typedef struct packed {
    logic [`MEM_AW-1:0]         add;   // word address
    logic [`MEM_DW-1:0]         data;  // write data
    logic [`MEM_DW/`MEM_BW-1:0] be;    // byte enables
    logic                       wen;   // high for read, low for write
  } mem_req_t;

  // read response word carried by the incoming FIFO
  typedef logic [`MEM_DW-1:0] mem_rdata_t;

  // status flags of a FIFO or of the whole buffer
  typedef struct packed {
    logic empty;  // nothing stored
    logic full;   // no room left
  } fifo_flags_t;

endpackage

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps
`include "mem_fifo_config.svh"

module sync_fifo
  import mem_fifo_pkg::*;
#(
  parameter type         T     = mem_rdata_t,
  parameter int unsigned DEPTH = `MEM_FIFO_DEPTH
)
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        push_valid_i,
  input  T            push_data_i,
  output logic        push_ready_o,
  output logic        pop_valid_o,
  output T            pop_data_o,
  input  logic        pop_ready_i,
  output fifo_flags_t flags_o
);

  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  T              mem_q [DEPTH];  // circular storage
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;        // occupancy
  logic          full;
  logic          empty;
  logic          push;
  logic          pop;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count_q == CW'(DEPTH));
  assign empty = (count_q == '0);

  assign push_ready_o = ~full | pop_ready_i;  // a pop frees the slot in the same cycle
  assign pop_valid_o  = ~empty;
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_ready_i & ~empty;

  assign flags_o.empty = empty;
  assign flags_o.full  = full;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (clear_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle or push with pop
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

//--- hdl/rsp_hold.sv
`timescale 1ns/1ps

module rsp_hold
  import mem_fifo_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       rvalid_i,      // fresh response from memory
  input  mem_rdata_t rdata_i,
  input  logic       fifo_ready_i,  // incoming FIFO accepts this cycle
  output logic       push_valid_o,
  output mem_rdata_t push_data_o
);

  logic       held_valid_q;
  mem_rdata_t held_data_q;

  // fresh data wins, the held copy only goes out when memory is quiet
  assign push_valid_o = rvalid_i | held_valid_q;
  assign push_data_o  = rvalid_i ? rdata_i : held_data_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      held_valid_q <= 1'b0;
    else if (clear_i)
      held_valid_q <= 1'b0;  // drop whatever is pending
    else if (rvalid_i)
      held_valid_q <= ~fifo_ready_i;  // keep it only if refused
    else if (held_valid_q && fifo_ready_i)
      held_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (rvalid_i)
      held_data_q <= rdata_i;
  end

endmodule

//--- hdl/mem_fifo_ctrl.sv
`timescale 1ns/1ps

module mem_fifo_ctrl
  import mem_fifo_pkg::*;
(
  input  logic        out_valid_i,  // outgoing FIFO has a request
  input  logic        in_ready_i,   // incoming FIFO can take a response
  input  logic        mem_gnt_i,
  output logic        mem_req_o,
  output logic        out_pop_o,
  input  fifo_flags_t out_flags_i,
  input  fifo_flags_t in_flags_i,
  output fifo_flags_t flags_o
);

  // A read granted now returns its word on the next cycle. Holding
  // requests back while the incoming side is blocked means at most one
  // response can be refused, and rsp_hold keeps that one.
  assign mem_req_o = out_valid_i & in_ready_i;

  // gnt only comes with req, so the room check above already applies
  assign out_pop_o = mem_gnt_i;

  assign flags_o.empty = out_flags_i.empty & in_flags_i.empty;  // whole buffer drained
  assign flags_o.full  = out_flags_i.full | in_flags_i.full;    // either side blocking

endmodule

//--- hdl/sram_bank.sv
`timescale 1ns/1ps
`include "mem_fifo_config.svh"

module sram_bank
  import mem_fifo_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  mem_req_t   bundle_i,
  input  logic       stall_i,   // withholds the grant
  output logic       gnt_o,
  output logic       rvalid_o,
  output mem_rdata_t rdata_o
);

  localparam int unsigned IW = $clog2(`SRAM_WORDS);
  localparam int unsigned NB = `MEM_DW / `MEM_BW;

  mem_rdata_t    mem_q [`SRAM_WORDS];
  logic [IW-1:0] idx;
  logic          rvalid_q;
  mem_rdata_t    rdata_q;

  assign gnt_o = req_i & ~stall_i;
  assign idx   = IW'(bundle_i.add % `SRAM_WORDS);  // wrap on the word count

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // model contents start at zero after reset
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int w = 0; w < `SRAM_WORDS; w++)
        mem_q[w] <= '0;
    end
    else if (gnt_o && !bundle_i.wen)
    begin
      for (int b = 0; b < NB; b++)
        if (bundle_i.be[b])
          mem_q[idx][b*`MEM_BW +: `MEM_BW] <= bundle_i.data[b*`MEM_BW +: `MEM_BW];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= gnt_o & bundle_i.wen;  // reads only, writes stay silent
  end

  always_ff @(posedge clk_i)
  begin
    if (gnt_o && bundle_i.wen)
      rdata_q <= mem_q[idx];
  end

endmodule

//--- hdl/mem_fifo_top.sv
`timescale 1ns/1ps
`include "mem_fifo_config.svh"

module mem_fifo_top
  import mem_fifo_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        core_req_i,
  input  mem_req_t    core_bundle_i,
  output logic        core_gnt_o,
  output logic        core_rvalid_o,
  output mem_rdata_t  core_rdata_o,
  input  logic        core_lrdy_i,
  input  logic        mem_stall_i,
  output fifo_flags_t flags_o
);

  logic        out_pop_valid;
  mem_req_t    out_pop_data;   // request as seen by the SRAM
  logic        out_pop;
  fifo_flags_t out_flags;
  logic        mem_req;
  logic        mem_gnt;
  logic        mem_rvalid;
  mem_rdata_t  mem_rdata;
  logic        in_push_valid;
  mem_rdata_t  in_push_data;
  logic        in_push_ready;
  fifo_flags_t in_flags;

  sync_fifo #(
    .T     ( mem_req_t       ),
    .DEPTH ( `MEM_FIFO_DEPTH )
  ) i_fifo_out (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( core_req_i    ),
    .push_data_i  ( core_bundle_i ),
    .push_ready_o ( core_gnt_o    ),  // full FIFO drops the core grant
    .pop_valid_o  ( out_pop_valid ),
    .pop_data_o   ( out_pop_data  ),
    .pop_ready_i  ( out_pop       ),
    .flags_o      ( out_flags     )
  );

  mem_fifo_ctrl i_ctrl (
    .out_valid_i ( out_pop_valid ),
    .in_ready_i  ( in_push_ready ),
    .mem_gnt_i   ( mem_gnt       ),
    .mem_req_o   ( mem_req       ),
    .out_pop_o   ( out_pop       ),
    .out_flags_i ( out_flags     ),
    .in_flags_i  ( in_flags      ),
    .flags_o     ( flags_o       )
  );

  sram_bank i_sram (
    .clk_i    ( clk_i        ),
    .rst_ni   ( rst_ni       ),
    .req_i    ( mem_req      ),
    .bundle_i ( out_pop_data ),
    .stall_i  ( mem_stall_i  ),
    .gnt_o    ( mem_gnt      ),
    .rvalid_o ( mem_rvalid   ),
    .rdata_o  ( mem_rdata    )
  );

  rsp_hold i_hold (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .rvalid_i     ( mem_rvalid    ),
    .rdata_i      ( mem_rdata     ),
    .fifo_ready_i ( in_push_ready ),
    .push_valid_o ( in_push_valid ),
    .push_data_o  ( in_push_data  )
  );

  sync_fifo #(
    .T     ( mem_rdata_t     ),
    .DEPTH ( `MEM_FIFO_DEPTH )
  ) i_fifo_in (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( in_push_valid ),
    .push_data_i  ( in_push_data  ),
    .push_ready_o ( in_push_ready ),
    .pop_valid_o  ( core_rvalid_o ),
    .pop_data_o   ( core_rdata_o  ),
    .pop_ready_i  ( core_lrdy_i   ),  // core stalls responses here
    .flags_o      ( in_flags      )
  );

endmodule

//--- bench/mem_fifo_tb.sv
`timescale 1ns/1ps
`include "mem_fifo_config.svh"

module mem_fifo_tb
  import mem_fifo_pkg::*;
();

  localparam int NB          = `MEM_DW / `MEM_BW;
  localparam int BURST_STALL = 12;  // stalled cycles at the start of the burst phase
  localparam int CLR_WATCH   = 8;   // cycles observed after a clear pulse

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  logic        core_req_i;
  mem_req_t    core_bundle_i;
  logic        core_gnt_o;
  logic        core_rvalid_o;
  mem_rdata_t  core_rdata_o;
  logic        core_lrdy_i;
  logic        mem_stall_i;
  fifo_flags_t flags_o;

  // case table, one entry per line of the case file
  string            case_name [$];
  bit               case_rd [$];
  logic [`MEM_AW-1:0] case_addr [$];
  mem_rdata_t       case_wdata [$];
  logic [NB-1:0]    case_be [$];
  mem_rdata_t       case_exp [$];

  // outstanding reads in request order
  mem_rdata_t exp_q [$];
  string      exp_name_q [$];

  int          mode = 0;          // 0 plain, 1 random stall, 2 random lrdy, 3 burst
  int          n_pass = 0;
  int          n_fail = 0;
  int          err_cnt = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000;
  int          burst_cycles = 0;
  bit          gnt_dropped = 1'b0;
  bit          full_at_drop = 1'b0;  // flags_o.full seen while gnt was low

  mem_fifo_top dut0 (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .core_req_i    ( core_req_i    ),
    .core_bundle_i ( core_bundle_i ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rdata_o  ( core_rdata_o  ),
    .core_lrdy_i   ( core_lrdy_i   ),
    .mem_stall_i   ( mem_stall_i   ),
    .flags_o       ( flags_o       )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task check_val(input string name, input mem_rdata_t exp, input mem_rdata_t act);
    if (exp !== act)
    begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      err_cnt = err_cnt + 1;
    end
  endtask

  task close_test(input string name, input int errs_before);
    if (err_cnt == errs_before)
    begin
      n_pass = n_pass + 1;
      $display("test %s passed", name);
    end
    else
    begin
      n_fail = n_fail + 1;
      $display("test %s failed", name);
    end
  endtask

  // the name prefix selects how stalls are applied
  function automatic int mode_of(input string name);
    string pre;
    pre = name.substr(0, 2);
    if (pre == "stl")
      return 1;
    else if (pre == "lrd")
      return 2;
    else if (pre == "bst")
      return 3;
    return 0;
  endfunction

  task load_cases;
    int         fd;
    int         n;
    string      line;
    string      name;
    string      op;
    logic [31:0] t_addr;
    mem_rdata_t t_data;
    logic [31:0] t_be;
    mem_rdata_t t_exp;
    fd = $fopen("bench/mem_fifo_cases.txt", "r");
    if (fd == 0)
      $display("cannot open bench/mem_fifo_cases.txt");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%s %s %h %h %h %h", name, op, t_addr, t_data, t_be, t_exp);
          if (n == 6)
          begin
            case_name.push_back(name);
            case_rd.push_back(op == "R");
            case_addr.push_back(t_addr[`MEM_AW-1:0]);
            case_wdata.push_back(t_data);
            case_be.push_back(t_be[NB-1:0]);
            case_exp.push_back(t_exp);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // presents one request and holds it until the grant
  task send_req(input int i);
    mem_req_t r;
    r.add  = case_addr[i];
    r.data = case_wdata[i];
    r.be   = case_be[i];
    r.wen  = case_rd[i];  // high for read
    core_req_i    <= 1'b1;
    core_bundle_i <= r;
    if (case_rd[i])
    begin
      exp_q.push_back(case_exp[i]);
      exp_name_q.push_back(case_name[i]);
    end
    do
      @(posedge clk_i);
    while (!core_gnt_o);
    if (!case_rd[i])
    begin
      n_pass = n_pass + 1;
      $display("test %s passed", case_name[i]);  // write done at its grant
    end
  endtask

  task finish_group(input int m);
    int e0;
    do
      @(posedge clk_i);
    while (exp_q.size() != 0 || !flags_o.empty);
    @(posedge clk_i);
    if (m == 3)
    begin
      e0 = err_cnt;
      check_val("bst_gnt_drop", mem_rdata_t'(1), mem_rdata_t'(gnt_dropped));
      check_val("bst_gnt_drop", mem_rdata_t'(1), mem_rdata_t'(full_at_drop));
      close_test("bst_gnt_drop", e0);
    end
  endtask

  task clear_check(input string name);
    int e0;
    e0 = err_cnt;
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    repeat (CLR_WATCH)
    begin
      @(posedge clk_i);
      check_val(name, mem_rdata_t'(1), mem_rdata_t'(flags_o.empty));
      check_val(name, mem_rdata_t'(0), mem_rdata_t'(core_rvalid_o));
    end
    close_test(name, e0);
  endtask

  task run_all;
    int cur;
    int m;
    cycle_limit = 64 * case_name.size() + 200;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    clear_check("clr_idle");
    cur = -1;
    for (int i = 0; i < case_name.size(); i++)
    begin
      m = mode_of(case_name[i]);
      if (m != cur)
      begin
        core_req_i <= 1'b0;
        finish_group(cur);  // drain before the stall pattern changes
        mode <= m;
        cur  = m;
        repeat (2) @(posedge clk_i);
      end
      send_req(i);
    end
    core_req_i <= 1'b0;
    finish_group(cur);
    clear_check("clr_drained");
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  endtask

  initial
  begin
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    core_req_i    = 1'b0;
    core_bundle_i = '0;
    load_cases;
    if (case_name.size() == 0)
    begin
      $display("no test cases could be read from the case file");
      $display("TEST FAILED");
      $finish;
    end
    else
      run_all;
  end

  // stall and lrdy levels, random where the phase asks for it
  initial
  begin
    void'($urandom(7));
    mem_stall_i = 1'b0;
    core_lrdy_i = 1'b1;
    forever
    begin
      @(posedge clk_i);
      if (mode != 3)
      begin
        burst_cycles = 0;
        gnt_dropped  = 1'b0;
        full_at_drop = 1'b0;
      end
      case (mode)
        1:
        begin
          mem_stall_i <= ($urandom % 2) == 0;
          core_lrdy_i <= 1'b1;
        end
        2:
        begin
          mem_stall_i <= 1'b0;
          core_lrdy_i <= ($urandom % 3) == 0;  // mostly low, fills the incoming FIFO
        end
        3:
        begin
          burst_cycles = burst_cycles + 1;
          if (core_req_i && !core_gnt_o)
          begin
            gnt_dropped = 1'b1;
            if (flags_o.full)
              full_at_drop = 1'b1;
          end
          mem_stall_i <= burst_cycles < BURST_STALL;  // fixed window, then release
          core_lrdy_i <= 1'b1;
        end
        default:
        begin
          mem_stall_i <= 1'b0;
          core_lrdy_i <= 1'b1;
        end
      endcase
    end
  end

  // response checker, in order against the expected queue
  always @(posedge clk_i)
  begin
    int    e0;
    string nm;
    if (rst_ni && core_rvalid_o && core_lrdy_i)
    begin
      if (exp_q.size() == 0)
      begin
        $display("unexpected read response %h with no read outstanding", core_rdata_o);
        err_cnt = err_cnt + 1;
      end
      else
      begin
        e0 = err_cnt;
        nm = exp_name_q.pop_front();
        check_val(nm, exp_q.pop_front(), core_rdata_o);
        close_test(nm, e0);
      end
    end
  end

endmodule

//--- bench/mem_fifo_cases.txt
# name op addr wdata be expected, all hex; expected is ignored for writes
# name prefix picks the phase: seq/mrg plain, stl mem stall, lrd core stall, bst burst
seq_w0 W 000 11111111 f 00000000
seq_w1 W 001 22222222 f 00000000
seq_w2 W 002 33333333 f 00000000
seq_w3 W 003 44444444 f 00000000
seq_r0 R 000 00000000 0 11111111
seq_r1 R 001 00000000 0 22222222
seq_r2 R 002 00000000 0 33333333
seq_r3 R 003 00000000 0 44444444
mrg_w0 W 001 aabbccdd 1 00000000
mrg_w1 W 002 aabbccdd 6 00000000
mrg_w2 W 003 deadbeef 8 00000000
mrg_w3 W 104 cafef00d f 00000000
mrg_r1 R 001 00000000 0 222222dd
mrg_r2 R 002 00000000 0 33bbcc33
mrg_r3 R 003 00000000 0 de444444
mrg_r4 R 204 00000000 0 cafef00d
stl_w0 W 010 01020304 f 00000000
stl_w1 W 011 a5a5a5a5 f 00000000
stl_r0 R 010 00000000 0 01020304
stl_w2 W 010 ffffffff 2 00000000
stl_r1 R 010 00000000 0 0102ff04
stl_r2 R 011 00000000 0 a5a5a5a5
stl_w3 W 011 5a000000 c 00000000
stl_r3 R 011 00000000 0 5a00a5a5
lrd_r0 R 000 00000000 0 11111111
lrd_r1 R 001 00000000 0 222222dd
lrd_r2 R 002 00000000 0 33bbcc33
lrd_r3 R 003 00000000 0 de444444
lrd_r4 R 004 00000000 0 cafef00d
lrd_r5 R 010 00000000 0 0102ff04
lrd_r6 R 011 00000000 0 5a00a5a5
lrd_r7 R 0a0 00000000 0 00000000
bst_w0 W 030 00000001 f 00000000
bst_w1 W 031 00000002 f 00000000
bst_w2 W 032 00000003 f 00000000
bst_r0 R 030 00000000 0 00000001
bst_r1 R 031 00000000 0 00000002
bst_r2 R 032 00000000 0 00000003
bst_r3 R 004 00000000 0 cafef00d

//--- src.f
+incdir+hdl
hdl/mem_fifo_pkg.sv
hdl/sync_fifo.sv
hdl/rsp_hold.sv
hdl/mem_fifo_ctrl.sv
hdl/sram_bank.sv
hdl/mem_fifo_top.sv
bench/mem_fifo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_fifo_tb
BUILD_DIR ?= build
FILELIST  ?= src.f
LOG       ?= sim.log
VFLAGS    ?=

SOURCES := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TEST PASSED$$" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
